//--- common/intc_pkg.sv
// Interrupt controller shared types: source count, interrupt id, vectors and config word
`default_nettype none

package intc_pkg;

  // Number of interrupt sources handled by the controller
  parameter int intc_num_src_default = 16;

  // Interrupt number, wide enough to name every source
  typedef logic [$clog2(intc_num_src_default)-1:0] intr_id_t;

  // One bit per source
  typedef logic [intc_num_src_default-1:0] intr_vec_t;

  // Configuration word written over the cfg handshake
  //   mask      : 1 enables the source
  //   edge_mode : 1 selects rising edge, 0 selects level
  typedef struct packed {
    intr_vec_t mask;
    intr_vec_t edge_mode;
  } intc_cfg_t;

  // Delivery report from the priority pipeline back to capture,
  // valid for exactly one cycle per completed handshake
  typedef struct packed {
    logic     valid;
    intr_id_t id;
  } intr_done_t;

endpackage : intc_pkg

`default_nettype wire

//--- src/intr_capture.sv
// Interrupt capture: source synchronizer, edge detection, pending bits and config port
`timescale 1ns/1ps
`default_nettype none

module intr_capture
  import intc_pkg::*;
#(
  parameter int num_src = intc_num_src_default
) (
  input  wire        clk,
  input  wire        rst_n,

  // Raw interrupt lines, asynchronous to clk
  input  intr_vec_t  src,

  // Four-phase configuration port
  input  wire        cfg_req,
  input  intc_cfg_t  cfg_data,
  output logic       cfg_ack,

  // Delivery report from the priority pipeline
  input  intr_done_t done,

  // Masked request vector towards the pipeline
  output intr_vec_t  active
);

  // Bits above num_src are never driven active
  localparam intr_vec_t src_used = intr_vec_t'((64'd1 << num_src) - 64'd1);

  // Two-flop synchronizer and previous-sample stage
  intr_vec_t src_meta;
  intr_vec_t src_sync;
  intr_vec_t src_prev;

  // Edge detection and pending state
  intr_vec_t rise;
  intr_vec_t done_hit;
  intr_vec_t pending;
  intr_vec_t pending_nxt;

  // Stored configuration
  intc_cfg_t cfg_q;

  // Synchronizer chain, the third stage doubles as the registered level
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      src_meta <= '0;
      src_sync <= '0;
      src_prev <= '0;
    end else begin
      src_meta <= src;
      src_sync <= src_meta;
      src_prev <= src_sync;
    end
  end

  // Rising edges, only recorded for sources in edge mode
  assign rise = src_sync & ~src_prev & cfg_q.edge_mode & src_used;

  // Decode the delivered id into a one-hot clear vector
  always_comb begin
    done_hit = '0;
    if (done.valid) begin
      done_hit[done.id] = 1'b1;
    end
  end

  // A fresh edge in the same cycle as the clear keeps the bit set
  assign pending_nxt = (pending & ~(done_hit & cfg_q.edge_mode)) | rise;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= '0;
    end else begin
      pending <= pending_nxt;
    end
  end

  // Config handshake
  // Data is taken when req is first seen, ack follows req down one cycle later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q   <= '0;
      cfg_ack <= 1'b0;
    end else if (cfg_req && !cfg_ack) begin
      cfg_q   <= cfg_data;
      cfg_ack <= 1'b1;
    end else if (!cfg_req && cfg_ack) begin
      cfg_ack <= 1'b0;
    end
  end

  // Edge sources present their pending bit, level sources their line.
  // Masked sources keep their pending bit so re-enabling delivers it
  assign active = cfg_q.mask & src_used &
                  ((cfg_q.edge_mode & pending) | (~cfg_q.edge_mode & src_prev));

endmodule : intr_capture

`default_nettype wire

//--- intr_prio/intr_prio_pipe.sv
// Priority pipeline: latch, encode highest active source, deliver over four-phase req/ack
`timescale 1ns/1ps
`default_nettype none

module intr_prio_pipe
  import intc_pkg::*;
#(
  parameter int num_src = intc_num_src_default
) (
  input  wire        clk,
  input  wire        rst_n,

  // Masked request vector from capture
  input  intr_vec_t  active,

  // Four-phase delivery port to the processor
  input  wire        irq_ack,
  output logic       irq_req,
  output intr_id_t   irq_id,

  // Completion report back to capture
  output intr_done_t done
);

  // Stage 1
  intr_vec_t s1_vec;
  logic      s1_valid;

  // Encoder between stage 1 and stage 2
  intr_id_t  enc_id;
  logic      enc_valid;

  // Stage 2
  intr_id_t  s2_id;
  logic      s2_valid;

  // Handshake bookkeeping
  logic      complete;
  logic      flush;
  logic      flush_q;
  logic      launch;
  logic      done_valid_q;
  intr_id_t  done_id_q;

  // First cycle of ack against a live request
  assign complete = irq_req && irq_ack;

  // Stages 1 and 2 stay empty from completion until ack has dropped,
  // so the next sample already sees the cleared pending bit
  assign flush = complete || flush_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flush_q <= 1'b0;
    end else if (complete) begin
      flush_q <= 1'b1;
    end else if (!irq_ack) begin
      flush_q <= 1'b0;
    end
  end

  // Stage 1 latches the request vector every cycle
  always_ff @(posedge clk) begin
    s1_vec <= active;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= !flush;
    end
  end

  // Highest numbered set bit wins
  always_comb begin
    enc_id = '0;
    for (int i = 0; i < num_src; i++) begin
      if (s1_vec[i]) begin
        enc_id = intr_id_t'(i);
      end
    end
    enc_valid = s1_valid && (|s1_vec);
  end

  // Stage 2 holds the encoded winner
  always_ff @(posedge clk) begin
    s2_id <= enc_id;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= enc_valid && !flush;
    end
  end

  // New request only from an idle port with ack already low
  assign launch = !irq_req && !irq_ack && !flush_q && s2_valid;

  // Stage 3 drives the delivery handshake
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_req <= 1'b0;
    end else if (launch) begin
      irq_req <= 1'b1;
    end else if (complete) begin
      irq_req <= 1'b0;
    end
  end

  // Id is held for the whole request
  always_ff @(posedge clk) begin
    if (launch) begin
      irq_id <= s2_id;
    end
  end

  // Single-cycle completion pulse with the delivered id
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_valid_q <= 1'b0;
    end else begin
      done_valid_q <= complete;
    end
  end

  always_ff @(posedge clk) begin
    done_id_q <= irq_id;
  end

  assign done = '{valid: done_valid_q, id: done_id_q};

endmodule : intr_prio_pipe

`default_nettype wire

//--- src/intc_top.sv
// Interrupt controller top: capture block feeding the priority delivery pipeline
`timescale 1ns/1ps
`default_nettype none

module intc_top
  import intc_pkg::*;
#(
  parameter int num_src = intc_num_src_default
) (
  input  wire       clk,
  input  wire       rst_n,

  // Raw interrupt sources
  input  intr_vec_t src,

  // Configuration port
  input  wire       cfg_req,
  input  intc_cfg_t cfg_data,
  output logic      cfg_ack,

  // Processor delivery port
  input  wire       irq_ack,
  output logic      irq_req,
  output intr_id_t  irq_id
);

  // Masked requests from capture to the pipeline
  intr_vec_t  active;

  // Completion report from the pipeline back to capture
  intr_done_t done;

  intr_capture #(
    .num_src  (num_src)
  ) intr_capture_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .src      (src),
    .cfg_req  (cfg_req),
    .cfg_data (cfg_data),
    .cfg_ack  (cfg_ack),
    .done     (done),
    .active   (active)
  );

  intr_prio_pipe #(
    .num_src  (num_src)
  ) intr_prio_pipe_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .active   (active),
    .irq_ack  (irq_ack),
    .irq_req  (irq_req),
    .irq_id   (irq_id),
    .done     (done)
  );

endmodule : intc_top

`default_nettype wire

//--- tb/intc_asserts.sv
// Interrupt controller assertions on the delivery and configuration handshakes
`timescale 1ns/1ps
`default_nettype none

module intc_asserts
  import intc_pkg::*;
(
  input wire           clk,
  input wire           rst_n,
  input wire           cfg_req,
  input wire           cfg_ack,
  input wire           irq_req,
  input wire           irq_ack,
  input wire intr_id_t irq_id
);

  // Failure counts per property and their sum
  int unsigned id_hold_errs = 0;
  int unsigned req_rise_errs = 0;
  int unsigned req_fall_errs = 0;
  int unsigned cfg_fall_errs = 0;
  int unsigned fail_total;

  assign fail_total = id_hold_errs + req_rise_errs + req_fall_errs + cfg_fall_errs;

  irq_id_stable : assert property (@(posedge clk) disable iff (!rst_n)
    irq_req |=> (!irq_req || $stable(irq_id)))
    else begin
      $error("irq_id changed while irq_req was high");
      id_hold_errs++;
    end

  // A new request only after the previous ack has dropped
  irq_req_rise : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(irq_req) |-> !$past(irq_ack))
    else begin
      $error("irq_req rose while irq_ack was high");
      req_rise_errs++;
    end

  irq_req_fall : assert property (@(posedge clk) disable iff (!rst_n)
    $fell(irq_req) |-> $past(irq_ack))
    else begin
      $error("irq_req fell without irq_ack");
      req_fall_errs++;
    end

  cfg_ack_fall : assert property (@(posedge clk) disable iff (!rst_n)
    $fell(cfg_ack) |-> !$past(cfg_req))
    else begin
      $error("cfg_ack fell while cfg_req was still high");
      cfg_fall_errs++;
    end

endmodule : intc_asserts

bind intc_top intc_asserts intc_asserts_i (
  .clk     (clk),
  .rst_n   (rst_n),
  .cfg_req (cfg_req),
  .cfg_ack (cfg_ack),
  .irq_req (irq_req),
  .irq_ack (irq_ack),
  .irq_id  (irq_id)
);

`default_nettype wire

//--- tb/intc_tb.sv
// Interrupt controller testbench with table-driven stimulus, processor model and reference checks
`timescale 1ns/1ps
`default_nettype none

module intc_tb
  import intc_pkg::*;
();

  localparam int num_src      = intc_num_src_default;
  localparam int num_rows     = 9;
  localparam int seed         = 83857;
  localparam int req_timeout  = 40;
  localparam int ack_timeout  = 10;
  localparam int cfg_timeout  = 10;
  localparam int quiet_cycles = 16;
  localparam int max_deliv    = 32;

  // Sources 0 to 3 are level, the rest rising edge
  localparam intr_vec_t edge_sel = 16'hFFF0;

  // One stimulus row
  //   reps : deliveries after which the held lines drop, 0 keeps them
  typedef struct packed {
    intc_cfg_t cfg;
    intr_vec_t pulse;
    intr_vec_t hold;
    intr_vec_t late;
    int        reps;
  } row_t;

  logic       clk = 1'b0;
  logic       rst_n;
  intr_vec_t  src;
  logic       cfg_req;
  intc_cfg_t  cfg_data;
  logic       cfg_ack;
  logic       irq_ack;
  logic       irq_req;
  intr_id_t   irq_id;

  intr_vec_t  lines_held;
  intr_vec_t  lines_pulsed;
  intr_vec_t  model_pending;
  row_t       rows [num_rows];
  intr_id_t   expect_q [$];
  int         mismatches;
  int         timeouts;
  int         assert_fails;

  assign src = lines_held | lines_pulsed;

  intc_top #(
    .num_src  (num_src)
  ) intc_top_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .src      (src),
    .cfg_req  (cfg_req),
    .cfg_data (cfg_data),
    .cfg_ack  (cfg_ack),
    .irq_ack  (irq_ack),
    .irq_req  (irq_req),
    .irq_id   (irq_id)
  );

  initial begin
    forever #20 clk = ~clk;
  end

  function automatic row_t make_row(input intr_vec_t mask, input intr_vec_t pulse,
                                    input intr_vec_t hold, input intr_vec_t late,
                                    input int reps);
    row_t r;
    r.cfg.mask      = mask;
    r.cfg.edge_mode = edge_sel;
    r.pulse         = pulse;
    r.hold          = hold;
    r.late          = late;
    r.reps          = reps;
    return r;
  endfunction

  task automatic load_table();
    // Nothing reaches the processor while the mask is clear
    rows[0] = make_row(16'h0000, 16'h0030, 16'h0004, 16'h0000, 0);
    // Enabling releases the stored edges and the level line
    rows[1] = make_row(16'hFFFF, 16'h0000, 16'h0004, 16'h0000, 3);
    rows[2] = make_row(16'hFFFF, 16'h8490, 16'h0000, 16'h0000, 0);
    // Level line redelivered until dropped
    rows[3] = make_row(16'hFFFF, 16'h0000, 16'h0002, 16'h0000, 4);
    // Source 11 rises while source 4 waits for ack
    rows[4] = make_row(16'hFFFF, 16'h0010, 16'h0000, 16'h0800, 0);
    rows[5] = make_row(16'hFFFF, 16'hFFF0, 16'h0000, 16'h0000, 0);
    // Source 9 pending but masked, then enabled
    rows[6] = make_row(16'hFDFF, 16'h0200, 16'h0000, 16'h0000, 0);
    rows[7] = make_row(16'hFFFF, 16'h0000, 16'h0000, 16'h0000, 0);
    rows[8] = make_row(16'hFFFF, 16'h0060, 16'h0008, 16'h0000, 4);
  endtask

  // Highest numbered set bit, -1 when empty
  function automatic int highest_set(input intr_vec_t v);
    int id;
    id = -1;
    for (int b = num_src - 1; b >= 0; b--) begin
      if (v[b] && id < 0) begin
        id = b;
      end
    end
    return id;
  endfunction

  // Reference model of one row, fills the expected delivery order
  task automatic predict_row(input row_t r);
    intr_vec_t lvl;
    intr_vec_t act;
    int        id;
    int        cnt;
    lvl = r.hold;
    cnt = 0;
    expect_q.delete();
    model_pending = model_pending | (r.pulse & r.cfg.edge_mode);
    act = r.cfg.mask & ((r.cfg.edge_mode & model_pending) | (~r.cfg.edge_mode & lvl));
    while (act != '0 && cnt < max_deliv) begin
      id = highest_set(act);
      expect_q.push_back(intr_id_t'(id));
      cnt++;
      if (r.cfg.edge_mode[id]) begin
        model_pending[id] = 1'b0;
      end
      if (cnt == 1) begin
        model_pending = model_pending | (r.late & r.cfg.edge_mode);
      end
      if (cnt == r.reps) begin
        lvl = '0;
      end
      act = r.cfg.mask & ((r.cfg.edge_mode & model_pending) | (~r.cfg.edge_mode & lvl));
    end
  endtask

  task automatic write_cfg(input intc_cfg_t c);
    int t;
    cfg_data = c;
    cfg_req  = 1'b1;
    t = 0;
    while (!cfg_ack && t < cfg_timeout) begin
      @(negedge clk);
      t++;
    end
    if (!cfg_ack) begin
      $display("Timeout: cfg_ack did not rise at %0t", $time);
      timeouts++;
    end
    cfg_req = 1'b0;
    t = 0;
    while (cfg_ack && t < cfg_timeout) begin
      @(negedge clk);
      t++;
    end
    if (cfg_ack) begin
      $display("Timeout: cfg_ack did not fall at %0t", $time);
      timeouts++;
    end
  endtask

  task automatic pulse_lines(input intr_vec_t p);
    lines_pulsed = p;
    repeat (2) @(negedge clk);
    lines_pulsed = '0;
  endtask

  // Processor model, acks each request after a random delay
  task automatic serve_row(input row_t r);
    int       t;
    int       delay;
    intr_id_t seen_id;
    for (int n = 0; n < expect_q.size(); n++) begin
      t = 0;
      while (!irq_req && t < req_timeout) begin
        @(negedge clk);
        t++;
      end
      if (!irq_req) begin
        $display("Timeout: no interrupt request for delivery %0d at %0t", n, $time);
        timeouts++;
        return;
      end
      if (irq_id !== expect_q[n]) begin
        $display("FAILED at %0t: delivery %0d gave id %0d, expected %0d",
                 $time, n, irq_id, expect_q[n]);
        mismatches++;
      end
      seen_id = irq_id;
      if (n == 0 && r.late != '0) begin
        pulse_lines(r.late);
      end
      delay = $urandom_range(5, 0);
      repeat (delay) @(negedge clk);
      if (irq_id !== seen_id) begin
        $display("FAILED at %0t: id changed from %0d to %0d while waiting for ack",
                 $time, seen_id, irq_id);
        mismatches++;
      end
      irq_ack = 1'b1;
      t = 0;
      while (irq_req && t < ack_timeout) begin
        @(negedge clk);
        t++;
      end
      if (irq_req) begin
        $display("Timeout: irq_req stayed high after ack at %0t", $time);
        timeouts++;
      end
      // Drop level lines before ack falls so the refill sees them low
      if (n + 1 == r.reps) begin
        lines_held = '0;
        repeat (5) @(negedge clk);
      end
      irq_ack = 1'b0;
      @(negedge clk);
    end
  endtask

  task automatic check_quiet();
    for (int t = 0; t < quiet_cycles; t++) begin
      @(negedge clk);
      if (irq_req) begin
        $display("FAILED at %0t: unexpected interrupt request with id %0d", $time, irq_id);
        mismatches++;
        return;
      end
    end
  endtask

  initial begin
    void'($urandom(seed));
    rst_n         = 1'b0;
    cfg_req       = 1'b0;
    cfg_data      = '0;
    irq_ack       = 1'b0;
    lines_held    = '0;
    lines_pulsed  = '0;
    model_pending = '0;
    mismatches    = 0;
    timeouts      = 0;
    assert_fails  = 0;
    load_table();
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);
    for (int i = 0; i < num_rows; i++) begin
      predict_row(rows[i]);
      write_cfg(rows[i].cfg);
      lines_held = rows[i].hold;
      if (rows[i].pulse != '0) begin
        pulse_lines(rows[i].pulse);
      end
      serve_row(rows[i]);
      check_quiet();
    end
    assert_fails = int'(intc_top_i.intc_asserts_i.fail_total);
    $display("Summary: %0d mismatches, %0d timeouts, %0d assertion failures",
             mismatches, timeouts, assert_fails);
    if (mismatches == 0 && timeouts == 0 && assert_fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule : intc_tb

`default_nettype wire

//--- project.f
common/intc_pkg.sv
src/intr_capture.sv
intr_prio/intr_prio_pipe.sv
src/intc_top.sv
tb/intc_asserts.sv
tb/intc_tb.sv

//--- Makefile
# Verilator lint and simulation for the interrupt controller

VERILATOR ?= verilator
FILELIST  ?= project.f
TB_TOP    ?= intc_tb
RTL_TOP   ?= intc_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= sim failed
PASS_MSG  ?= sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Run reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Run ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
